// File: hw/fifo_geom_pkg.sv
package fifo_geom_pkg;

  // Port widths
  localparam int WR_DATA_W = 32;
  localparam int RD_DATA_W = 8;

  // Byte lanes per word, one RAM bank per lane
  localparam int RATIO  = WR_DATA_W / RD_DATA_W;
  localparam int LANE_W = $clog2(RATIO);

  // Bank rows shared by all lanes
  localparam int ROW_ADDR_W = 5;

  // Capacity counted in read-side bytes
  localparam int DEPTH_BYTES = RATIO * (2 ** ROW_ADDR_W);
  localparam int LEVEL_W     = $clog2(DEPTH_BYTES + 1);

  // Read sequencer state codes
  localparam int SEQ_STATE_W = 2;
  localparam logic [SEQ_STATE_W-1:0] SEQ_IDLE       = 2'd0;
  localparam logic [SEQ_STATE_W-1:0] SEQ_SERVE      = 2'd1;
  localparam logic [SEQ_STATE_W-1:0] SEQ_SERVE_WRAP = 2'd2;

endpackage

// File: hw/fifo_word_pkg.sv
package fifo_word_pkg;

  import fifo_geom_pkg::*;

  // Write word seen either whole or as byte lanes, lane 0 lowest
  typedef union packed {
    logic [WR_DATA_W-1:0]                word;
    logic [RATIO-1:0][RD_DATA_W-1:0]     lanes;
  } wide_word_u;

endpackage

// File: hw/fifo_dp_ram.sv
`timescale 1ns/100ps

module fifo_dp_ram (
  input  logic                                clk,
  input  logic                                wr_en,
  input  logic [fifo_geom_pkg::ROW_ADDR_W-1:0] wr_addr,
  input  logic [fifo_geom_pkg::RD_DATA_W-1:0]  wr_data,
  input  logic                                rd_en,
  input  logic [fifo_geom_pkg::ROW_ADDR_W-1:0] rd_addr,
  output logic [fifo_geom_pkg::RD_DATA_W-1:0]  rd_data
);

  import fifo_geom_pkg::*;

  // One byte lane for every row
  logic [RD_DATA_W-1:0] mem [0:(2**ROW_ADDR_W)-1];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Registered read, output holds while idle
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: hw/fifo_write_port.sv
`timescale 1ns/100ps

module fifo_write_port (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 wr_en,
  input  logic                                 full,
  input  fifo_word_pkg::wide_word_u            wr_data,
  output logic                                 wr_accept,
  output logic [fifo_geom_pkg::ROW_ADDR_W-1:0] wr_row,
  output fifo_word_pkg::wide_word_u            wr_lanes
);

  import fifo_geom_pkg::*;
  import fifo_word_pkg::*;

  // Request is dropped while full
  assign wr_accept = wr_en & ~full;

  // Row pointer wraps naturally at the bank depth
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_row <= '0;
    end else if (wr_accept) begin
      wr_row <= wr_row + 1'b1;
    end
  end

  // Cut the whole word into byte lanes, lowest byte to lane 0
  always_comb begin
    for (int i = 0; i < RATIO; i++) begin
      wr_lanes.lanes[i] = wr_data.word[i*RD_DATA_W +: RD_DATA_W];
    end
  end

endmodule

// File: hw/fifo_occupancy_counter.sv
`timescale 1ns/100ps

module fifo_occupancy_counter (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              wr_accept,
  input  logic                              rd_accept,
  output logic [fifo_geom_pkg::LEVEL_W-1:0] level,
  output logic                              full,
  output logic                              empty
);

  import fifo_geom_pkg::*;

  logic [LEVEL_W-1:0] level_next;

  // A word adds RATIO bytes, a read takes one
  always_comb begin
    case ({wr_accept, rd_accept})
      2'b10:   level_next = level + LEVEL_W'(RATIO);
      2'b01:   level_next = level - 1'b1;
      2'b11:   level_next = level + LEVEL_W'(RATIO - 1);
      default: level_next = level;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      level <= '0;
    end else begin
      level <= level_next;
    end
  end

  // Full once a whole word no longer fits
  assign full  = level > LEVEL_W'(DEPTH_BYTES - RATIO);
  assign empty = level == '0;

endmodule

// File: hw/fifo_read_sequencer.sv
`timescale 1ns/100ps

module fifo_read_sequencer (
  input  logic                                                       clk,
  input  logic                                                       rst,
  input  logic                                                       rd_en,
  input  logic                                                       empty,
  input  logic [fifo_geom_pkg::RATIO-1:0][fifo_geom_pkg::RD_DATA_W-1:0] bank_rdata,
  output logic                                                       rd_accept,
  output logic [fifo_geom_pkg::ROW_ADDR_W-1:0]                       rd_row,
  output logic [fifo_geom_pkg::RD_DATA_W-1:0]                        rd_data,
  output logic                                                       rd_valid
);

  import fifo_geom_pkg::*;

  logic [SEQ_STATE_W-1:0] state;
  logic [SEQ_STATE_W-1:0] state_next;
  logic [LANE_W-1:0]      lane;
  logic [LANE_W-1:0]      lane_in_flight;
  logic                   last_lane;

  assign rd_accept = rd_en & ~empty;
  assign last_lane = lane == LANE_W'(RATIO - 1);

  // Serve states last one cycle per accepted read
  always_comb begin
    if (rd_accept) begin
      state_next = last_lane ? SEQ_SERVE_WRAP : SEQ_SERVE;
    end else begin
      state_next = SEQ_IDLE;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= SEQ_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Lane walks 0..RATIO-1, row moves after the last lane
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane   <= '0;
      rd_row <= '0;
    end else if (rd_accept) begin
      lane <= lane + 1'b1;
      if (last_lane) begin
        rd_row <= rd_row + 1'b1;
      end
    end
  end

  // Remember which bank answers the read in flight
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      lane_in_flight <= '0;
    end else if (rd_accept) begin
      lane_in_flight <= lane;
    end
  end

  assign rd_data = bank_rdata[lane_in_flight];

  assign rd_valid = (state == SEQ_SERVE) || (state == SEQ_SERVE_WRAP);

endmodule

// File: hw/fifo_asym_top.sv
`timescale 1ns/100ps

module fifo_asym_top (
  input  logic                              clk,
  input  logic                              rst,
  input  fifo_word_pkg::wide_word_u         wr_data,
  input  logic                              wr_en,
  input  logic                              rd_en,
  output logic                              full,
  output logic [fifo_geom_pkg::RD_DATA_W-1:0] rd_data,
  output logic                              rd_valid,
  output logic                              empty,
  output logic [fifo_geom_pkg::LEVEL_W-1:0] level
);

  import fifo_geom_pkg::*;
  import fifo_word_pkg::*;

  logic                            wr_accept;
  logic [ROW_ADDR_W-1:0]           wr_row;
  wide_word_u                      wr_lanes;
  logic                            rd_accept;
  logic [ROW_ADDR_W-1:0]           rd_row;
  logic [RATIO-1:0][RD_DATA_W-1:0] bank_rdata;

  fifo_write_port u_write_port (
    .clk       (clk),
    .rst       (rst),
    .wr_en     (wr_en),
    .full      (full),
    .wr_data   (wr_data),
    .wr_accept (wr_accept),
    .wr_row    (wr_row),
    .wr_lanes  (wr_lanes)
  );

  fifo_occupancy_counter u_counter (
    .clk       (clk),
    .rst       (rst),
    .wr_accept (wr_accept),
    .rd_accept (rd_accept),
    .level     (level),
    .full      (full),
    .empty     (empty)
  );

  fifo_read_sequencer u_read_seq (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (rd_en),
    .empty      (empty),
    .bank_rdata (bank_rdata),
    .rd_accept  (rd_accept),
    .rd_row     (rd_row),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid)
  );

  // Bank i stores byte lane i of every row
  for (genvar i = 0; i < RATIO; i++) begin : g_bank
    fifo_dp_ram u_bank (
      .clk     (clk),
      .wr_en   (wr_accept),
      .wr_addr (wr_row),
      .wr_data (wr_lanes.lanes[i]),
      .rd_en   (rd_accept),
      .rd_addr (rd_row),
      .rd_data (bank_rdata[i])
    );
  end

endmodule

// File: tb/fifo_asym_tb.sv
`timescale 1ns/100ps

module fifo_asym_tb;

  import fifo_geom_pkg::*;
  import fifo_word_pkg::*;

  localparam int RESET_CYCLES  = 16;
  localparam int RANDOM_CYCLES = 1500;
  localparam int CYCLE_LIMIT   = 3000;

  logic                 clk;
  logic                 rst;
  wide_word_u           wr_data;
  logic                 wr_en;
  logic                 rd_en;
  logic                 full;
  logic [RD_DATA_W-1:0] rd_data;
  logic                 rd_valid;
  logic                 empty;
  logic [LEVEL_W-1:0]   level;

  // Reference model state
  logic [RD_DATA_W-1:0] ref_q [$];
  int                   model_level;
  logic                 exp_valid;
  logic [RD_DATA_W-1:0] exp_byte;
  int                   cycle_count;

  fifo_asym_top dut (
    .clk      (clk),
    .rst      (rst),
    .wr_data  (wr_data),
    .wr_en    (wr_en),
    .rd_en    (rd_en),
    .full     (full),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .empty    (empty),
    .level    (level)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped");
  endtask

  // Acceptance is judged from the flags seen before the edge
  always @(posedge clk) begin : ref_model
    logic [RD_DATA_W-1:0] head;
    int                   next_level;
    head = '0;
    next_level = model_level;
    if (rst) begin
      ref_q.delete();
      model_level <= 0;
      exp_valid   <= 1'b0;
      exp_byte    <= '0;
    end else if (rd_en && !empty && ref_q.size() == 0) begin
      abort_run("Read accepted while the reference queue holds no bytes");
    end else begin
      exp_valid <= rd_en && !empty;
      if (rd_en && !empty) begin
        head = ref_q.pop_front();
        exp_byte <= head;
        next_level = next_level - 1;
      end
      if (wr_en && !full) begin
        // Lowest lane leaves first
        for (int i = 0; i < RATIO; i++) begin
          ref_q.push_back(wr_data.lanes[i]);
        end
        next_level = next_level + RATIO;
      end
      model_level <= next_level;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  a_reset_state: assert property (@(posedge clk)
    (rst || $fell(rst)) |-> (!rd_valid && empty && !full && level == '0))
    else abort_run($sformatf("** Error %0t: outputs not in reset state", $time));

  a_valid: assert property (@(posedge clk) disable iff (rst)
    rd_valid == exp_valid)
    else abort_run($sformatf("** Error %0t: rd_valid %0b, expected %0b",
                             $time, rd_valid, exp_valid));

  a_data: assert property (@(posedge clk) disable iff (rst)
    rd_valid |-> rd_data == exp_byte)
    else abort_run($sformatf("** Error %0t: rd_data %02h, expected %02h",
                             $time, rd_data, exp_byte));

  a_level: assert property (@(posedge clk) disable iff (rst)
    int'(level) == model_level)
    else abort_run($sformatf("** Error %0t: level %0d, expected %0d",
                             $time, level, model_level));

  // Full leaves no room for a whole word
  a_flags: assert property (@(posedge clk) disable iff (rst)
    full == (model_level > DEPTH_BYTES - RATIO) && empty == (model_level == 0))
    else abort_run($sformatf("** Error %0t: full %0b empty %0b at model level %0d",
                             $time, full, empty, model_level));

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      wr_en <= 1'b0;
      rd_en <= 1'b0;
    end
  endtask

  task automatic write_words(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      wr_en        <= 1'b1;
      wr_data.word <= $urandom;
    end
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic read_bytes(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      rd_en <= 1'b1;
    end
    @(posedge clk);
    rd_en <= 1'b0;
  endtask

  // Both sides in the same edge
  task automatic write_and_read(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      wr_en        <= 1'b1;
      rd_en        <= 1'b1;
      wr_data.word <= $urandom;
    end
    @(posedge clk);
    wr_en <= 1'b0;
    rd_en <= 1'b0;
  endtask

  task automatic fill_to_full(input int extra);
    @(posedge clk);
    while (!full) begin
      wr_en        <= 1'b1;
      wr_data.word <= $urandom;
      @(posedge clk);
    end
    // Keep pushing against full
    repeat (extra) begin
      wr_data.word <= $urandom;
      @(posedge clk);
    end
    wr_en <= 1'b0;
    @(posedge clk);
  endtask

  task automatic drain();
    @(posedge clk);
    wr_en <= 1'b0;
    rd_en <= 1'b1;
    do begin
      @(posedge clk);
    end while (!empty);
    rd_en <= 1'b0;
  endtask

  task automatic random_traffic(input int cycles);
    int unsigned wr_pct;
    wr_pct = 20;
    for (int c = 0; c < cycles; c++) begin
      // Bias shifts so the FIFO swings between full and empty
      if (c % 250 == 0) begin
        wr_pct = $urandom_range(45, 10);
      end
      @(posedge clk);
      wr_en        <= ($urandom_range(99) < wr_pct);
      rd_en        <= ($urandom_range(99) < 80);
      wr_data.word <= $urandom;
    end
    @(posedge clk);
    wr_en <= 1'b0;
    rd_en <= 1'b0;
  endtask

  initial begin
    void'($urandom(32'hc803));
    rst          = 1'b1;
    wr_en        = 1'b0;
    rd_en        = 1'b0;
    wr_data      = '0;
    cycle_count  = 0;
    model_level  = 0;
    exp_valid    = 1'b0;
    exp_byte     = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    idle(2);

    // Byte order
    write_words(3);
    read_bytes(12);
    idle(3);
    assert (level == '0 && empty)
      else abort_run($sformatf("** Error %0t: level %0d after twelve reads", $time, level));

    // Write and read in one edge
    write_words(2);
    write_and_read(4);
    drain();
    idle(2);

    fill_to_full(6);
    assert (int'(level) == DEPTH_BYTES && full)
      else abort_run($sformatf("** Error %0t: level %0d after fill", $time, level));
    drain();
    idle(2);

    // Reads against an empty FIFO
    read_bytes(10);
    idle(2);
    assert (level == '0 && empty && !rd_valid)
      else abort_run($sformatf("** Error %0t: reads while empty moved the FIFO", $time));

    random_traffic(RANDOM_CYCLES);
    drain();
    idle(2);
    if (ref_q.size() != 0 || !empty) begin
      abort_run("Bytes left in the reference queue after the final drain");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: flist.f
hw/fifo_geom_pkg.sv
hw/fifo_word_pkg.sv
hw/fifo_dp_ram.sv
hw/fifo_write_port.sv
hw/fifo_occupancy_counter.sv
hw/fifo_read_sequencer.sv
hw/fifo_asym_top.sv
tb/fifo_asym_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := fifo_asym_tb
FLIST      := flist.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Pass only when the testbench prints its pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
